//--- source/csr_pkg.sv
// CSR block shared definitions
`default_nettype none

package csr_pkg;

	localparam int XLEN       = 32;
	localparam int NUM_IRQ    = 16;
	localparam int N_COUNTERS = 2;
	localparam int CTR_CYCLE   = 0; // Slice index of mcycle
	localparam int CTR_INSTRET = 1; // Slice index of minstret

	typedef logic [XLEN-1:0]    xlen_t;
	typedef logic [11:0]        csr_addr_t;
	typedef logic [NUM_IRQ-1:0] irq_vec_t;
	typedef logic [5:0]         cause_code_t;
	typedef logic [63:0]        count_t;

	typedef enum logic [1:0] {
		wtype_write = 2'd0,
		wtype_set   = 2'd1,
		wtype_clear = 2'd2
	} csr_wtype_e;

	// Synchronous exception causes, numbered as mcause codes
	typedef enum logic [3:0] {
		except_instr_misalign = 4'd0,
		except_instr_fault    = 4'd1,
		except_illegal        = 4'd2,
		except_ebreak         = 4'd3,
		except_load_misalign  = 4'd4,
		except_load_fault     = 4'd5,
		except_store_misalign = 4'd6,
		except_store_fault    = 4'd7,
		except_mret           = 4'd10, // Not a trap, return request
		except_ecall          = 4'd11,
		except_none           = 4'd15
	} except_e;

	// ------------------------------
	// CSR addresses
	localparam csr_addr_t CSR_MSTATUS       = 12'h300;
	localparam csr_addr_t CSR_MISA          = 12'h301;
	localparam csr_addr_t CSR_MIE           = 12'h304;
	localparam csr_addr_t CSR_MTVEC         = 12'h305;
	localparam csr_addr_t CSR_MCOUNTINHIBIT = 12'h320;
	localparam csr_addr_t CSR_MEPC          = 12'h341;
	localparam csr_addr_t CSR_MCAUSE        = 12'h342;
	localparam csr_addr_t CSR_MTVAL         = 12'h343; // Reads zero
	localparam csr_addr_t CSR_MIP           = 12'h344;
	localparam csr_addr_t CSR_MCYCLE        = 12'hb00;
	localparam csr_addr_t CSR_MINSTRET      = 12'hb02;
	localparam csr_addr_t CSR_MCYCLEH       = 12'hb80;
	localparam csr_addr_t CSR_MINSTRETH     = 12'hb82;
	localparam csr_addr_t CSR_MEIE0         = 12'hbe0; // Custom, external enables
	localparam csr_addr_t CSR_MEIP0         = 12'hfe0; // Custom, read only
	localparam csr_addr_t CSR_MLEI          = 12'hfe4; // Custom, read only

	// ------------------------------
	// Writable bits and reset values
	localparam xlen_t MSTATUS_WMASK       = 32'h0000_0088; // mpie, mie
	localparam xlen_t MIE_WMASK           = 32'h0000_0888; // meie, mtie, msie
	localparam xlen_t MEIE0_WMASK         = ~({XLEN{1'b1}} << NUM_IRQ);
	localparam xlen_t MTVEC_INIT          = 32'h0000_0000;
	localparam xlen_t MTVEC_WMASK         = 32'hffff_fffd; // Mode bit 1 is reserved
	localparam xlen_t MEPC_MASK           = 32'hffff_fffe;
	localparam xlen_t MCAUSE_WMASK        = 32'h8000_003f; // irq flag and code
	localparam xlen_t MCOUNTINHIBIT_WMASK = 32'h0000_0005; // ir and cy
	localparam xlen_t MISA_VAL            = 32'h4000_0100; // MXL=1, I only

	// Write, set or clear merge restricted to the writable bits
	function automatic xlen_t csr_update(input xlen_t prev, input xlen_t wdata,
		input csr_wtype_e wtype, input xlen_t wmask);
		xlen_t merged;
		case (wtype)
			wtype_set:   merged = prev | wdata;
			wtype_clear: merged = prev & ~wdata;
			default:     merged = wdata;
		endcase
		return (merged & wmask) | (prev & ~wmask); // Fixed bits keep old value
	endfunction

endpackage

`default_nettype wire

//--- source/csr_counter_access.sv
// Counter access decode
`default_nettype none

module csr_counter_access (
	input  wire                     clk,
	input  wire                     rst_n,
	input  wire csr_pkg::csr_addr_t  addr,
	input  wire csr_pkg::xlen_t      wdata,
	input  wire csr_pkg::csr_wtype_e wtype,
	input  wire                     wen,
	input  wire                     instr_ret,
	output logic [csr_pkg::N_COUNTERS-1:0] inc,
	output logic [csr_pkg::N_COUNTERS-1:0] wen_lo,
	output logic [csr_pkg::N_COUNTERS-1:0] wen_hi,
	output logic                    inhibit_cy,
	output logic                    inhibit_ir
);
	import csr_pkg::*;

	xlen_t inhibit_upd; // Merged mcountinhibit value on a write

	assign inhibit_upd = csr_update({29'd0, inhibit_ir, 1'b0, inhibit_cy}, wdata, wtype,
		MCOUNTINHIBIT_WMASK);

	// mcountinhibit, bit 0 stops mcycle and bit 2 stops minstret
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			inhibit_cy <= 1'b0;
			inhibit_ir <= 1'b0;
		end else if (wen && addr == CSR_MCOUNTINHIBIT) begin
			inhibit_cy <= inhibit_upd[0];
			inhibit_ir <= inhibit_upd[2];
		end
	end

	// Word write strobes per slice
	assign wen_lo[CTR_CYCLE]   = wen && addr == CSR_MCYCLE;
	assign wen_hi[CTR_CYCLE]   = wen && addr == CSR_MCYCLEH;
	assign wen_lo[CTR_INSTRET] = wen && addr == CSR_MINSTRET;
	assign wen_hi[CTR_INSTRET] = wen && addr == CSR_MINSTRETH;

	assign inc[CTR_CYCLE]   = !inhibit_cy;              // Every clock
	assign inc[CTR_INSTRET] = instr_ret && !inhibit_ir; // Per retired instruction

endmodule

`default_nettype wire

//--- source/csr_counter_slice.sv
// 64-bit event counter
`default_nettype none

module csr_counter_slice (
	input  wire                     clk,
	input  wire                     rst_n,
	input  wire                     inc,
	input  wire                     wen_lo,
	input  wire                     wen_hi,
	input  wire csr_pkg::xlen_t      wdata,
	input  wire csr_pkg::csr_wtype_e wtype,
	output csr_pkg::count_t         count
);
	import csr_pkg::*;

	count_t count_inc; // Carry runs through both words

	assign count_inc = count + {63'd0, inc};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			count <= '0;
		end else begin
			// A software write wins only for the word it targets
			count[31:0]  <= wen_lo ? csr_update(count[31:0], wdata, wtype, '1)
				: count_inc[31:0];
			count[63:32] <= wen_hi ? csr_update(count[63:32], wdata, wtype, '1)
				: count_inc[63:32];
		end
	end

endmodule

`default_nettype wire

//--- source/csr_mtrap_regs.sv
// Machine trap setup and handling registers
`default_nettype none

module csr_mtrap_regs (
	input  wire                      clk,
	input  wire                      rst_n,
	input  wire csr_pkg::csr_addr_t   addr,
	input  wire csr_pkg::xlen_t       wdata,
	input  wire csr_pkg::csr_wtype_e  wtype,
	input  wire                      wen,
	input  wire                      trap_take,   // Trap accepted
	input  wire                      trap_return, // mret accepted
	input  wire                      cause_irq,
	input  wire csr_pkg::cause_code_t cause_code,
	input  wire csr_pkg::xlen_t       mepc_in,
	output logic                     mstatus_mie,
	output logic                     mstatus_mpie,
	output csr_pkg::xlen_t           mie,
	output csr_pkg::xlen_t           meie0,
	output csr_pkg::xlen_t           mtvec,
	output csr_pkg::xlen_t           mepc,
	output logic                     mcause_irq,
	output csr_pkg::cause_code_t     mcause_code
);
	import csr_pkg::*;

	xlen_t mstatus_upd;
	xlen_t mcause_upd;

	assign mstatus_upd = csr_update({24'd0, mstatus_mpie, 3'd0, mstatus_mie, 3'd0}, wdata,
		wtype, MSTATUS_WMASK);
	assign mcause_upd = csr_update({mcause_irq, 25'd0, mcause_code}, wdata, wtype,
		MCAUSE_WMASK);

	// ------------------------------
	// Interrupt enable stack, trap entry and return first
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mstatus_mie  <= 1'b0;
			mstatus_mpie <= 1'b0;
		end else if (trap_take) begin
			mstatus_mpie <= mstatus_mie; // Push
			mstatus_mie  <= 1'b0;
		end else if (trap_return) begin
			mstatus_mie  <= mstatus_mpie; // Pop
			mstatus_mpie <= 1'b1;
		end else if (wen && addr == CSR_MSTATUS) begin
			mstatus_mie  <= mstatus_upd[3];
			mstatus_mpie <= mstatus_upd[7];
		end
	end

	// Trap state captured on entry
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mepc        <= '0;
			mcause_irq  <= 1'b0;
			mcause_code <= '0;
		end else if (trap_take) begin
			mepc        <= mepc_in & MEPC_MASK;
			mcause_irq  <= cause_irq;
			mcause_code <= cause_code;
		end else if (wen) begin
			if (addr == CSR_MEPC)
				mepc <= csr_update(mepc, wdata, wtype, MEPC_MASK);
			if (addr == CSR_MCAUSE) begin
				mcause_irq  <= mcause_upd[31];
				mcause_code <= mcause_upd[5:0];
			end
		end
	end

	// ------------------------------
	// Software-only registers
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mtvec <= MTVEC_INIT;
			mie   <= '0;
			meie0 <= '0;
		end else if (wen) begin
			if (addr == CSR_MTVEC)
				mtvec <= csr_update(mtvec, wdata, wtype, MTVEC_WMASK); // Bit 0 selects vectored
			if (addr == CSR_MIE)
				mie <= csr_update(mie, wdata, wtype, MIE_WMASK);
			if (addr == CSR_MEIE0)
				meie0 <= csr_update(meie0, wdata, wtype, MEIE0_WMASK);
		end
	end

endmodule

`default_nettype wire

//--- source/csr_trap_ctrl.sv
// Interrupt pending and trap request logic
`default_nettype none

module csr_trap_ctrl (
	input  wire                   clk,
	input  wire                   rst_n,
	input  wire csr_pkg::irq_vec_t irq,
	input  wire                   irq_software,
	input  wire                   irq_timer,
	input  wire                   delay_irq_entry,
	input  wire csr_pkg::except_e  except,
	input  wire                   trap_enter_rdy,
	input  wire                   mstatus_mie,
	input  wire csr_pkg::xlen_t    mie,
	input  wire csr_pkg::xlen_t    meie0,
	input  wire csr_pkg::xlen_t    mtvec,
	input  wire csr_pkg::xlen_t    mepc,
	output csr_pkg::xlen_t        mip,
	output csr_pkg::xlen_t        meip0,
	output logic [4:0]            mlei,
	output logic                  trap_enter_vld,
	output logic                  trap_is_irq,
	output csr_pkg::xlen_t        trap_addr,
	output logic                  trap_take,
	output logic                  trap_return,
	output logic                  cause_irq,
	output csr_pkg::cause_code_t  cause_code
);
	import csr_pkg::*;

	irq_vec_t    irq_r;
	logic        irq_software_r;
	logic        irq_timer_r;
	irq_vec_t    ext_req;     // Enabled and pending external lines
	logic [11:0] std_req;     // Enabled and pending msip, mtip, meip
	logic [3:0]  std_num;
	logic        exception_req;
	logic        irq_req;
	cause_code_t vector_sel;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			irq_r          <= '0;
			irq_software_r <= 1'b0;
			irq_timer_r    <= 1'b0;
		end else begin
			irq_r          <= irq;
			irq_software_r <= irq_software;
			irq_timer_r    <= irq_timer;
		end
	end

	assign meip0   = {{(XLEN - NUM_IRQ){1'b0}}, irq_r};
	assign ext_req = meie0[NUM_IRQ-1:0] & irq_r;
	assign mip     = {20'd0, |ext_req, 3'd0, irq_timer_r, 3'd0, irq_software_r, 3'd0};
	assign std_req = mip[11:0] & mie[11:0];

	// ------------------------------
	// Lowest index wins in both encoders
	always_comb begin
		mlei = '0;
		for (int i = NUM_IRQ - 1; i >= 0; i--) begin
			if (ext_req[i])
				mlei = 5'(i);
		end
	end

	always_comb begin
		std_num = '0;
		for (int i = 11; i >= 0; i--) begin
			if (std_req[i])
				std_num = 4'(i);
		end
	end

	// ------------------------------
	// Trap request
	assign exception_req  = except != except_none; // ebreak included
	assign irq_req        = !delay_irq_entry && mstatus_mie && |std_req;
	assign trap_enter_vld = exception_req || irq_req;
	assign trap_is_irq    = !exception_req;

	// Vector offset only for interrupts in vectored mode
	assign vector_sel = (exception_req || !mtvec[0]) ? '0 : {2'd0, std_num};
	assign trap_addr  = except == except_mret ? mepc
		: {mtvec[XLEN-1:2], 2'b00} + {24'd0, vector_sel, 2'b00};

	assign cause_irq  = !exception_req;
	assign cause_code = exception_req ? {2'd0, except} : {2'd0, std_num};

	assign trap_take   = trap_enter_vld && trap_enter_rdy && except != except_mret;
	assign trap_return = trap_enter_vld && trap_enter_rdy && except == except_mret;

endmodule

`default_nettype wire

//--- source/csr_read_mux.sv
// CSR read port and decode
`default_nettype none

module csr_read_mux (
	input  wire csr_pkg::csr_addr_t   addr,
	input  wire                      wen,
	input  wire                      ren,
	input  wire                      mstatus_mie,
	input  wire                      mstatus_mpie,
	input  wire csr_pkg::xlen_t       mie,
	input  wire csr_pkg::xlen_t       meie0,
	input  wire csr_pkg::xlen_t       mtvec,
	input  wire csr_pkg::xlen_t       mepc,
	input  wire                      mcause_irq,
	input  wire csr_pkg::cause_code_t mcause_code,
	input  wire csr_pkg::xlen_t       mip,
	input  wire csr_pkg::xlen_t       meip0,
	input  wire [4:0]                mlei,
	input  wire                      inhibit_cy,
	input  wire                      inhibit_ir,
	input  wire csr_pkg::count_t      counts [csr_pkg::N_COUNTERS],
	output csr_pkg::xlen_t           rdata,
	output logic                     illegal
);
	import csr_pkg::*;

	logic decode_match; // Address maps to an implemented register

	always_comb begin
		decode_match = 1'b1;
		rdata        = '0;
		case (addr)
			CSR_MSTATUS:       rdata = {19'd0, 2'b11, 3'd0, mstatus_mpie, 3'd0, mstatus_mie, 3'd0};
			CSR_MISA:          rdata = MISA_VAL; // Writes ignored
			CSR_MIE:           rdata = mie;
			CSR_MTVEC:         rdata = mtvec;
			CSR_MEPC:          rdata = mepc;
			CSR_MCAUSE:        rdata = {mcause_irq, 25'd0, mcause_code};
			CSR_MTVAL:         rdata = '0;
			CSR_MIP:           rdata = mip; // Writes accepted, no effect
			CSR_MCOUNTINHIBIT: rdata = {29'd0, inhibit_ir, 1'b0, inhibit_cy};
			CSR_MCYCLE:        rdata = counts[CTR_CYCLE][31:0];
			CSR_MCYCLEH:       rdata = counts[CTR_CYCLE][63:32];
			CSR_MINSTRET:      rdata = counts[CTR_INSTRET][31:0];
			CSR_MINSTRETH:     rdata = counts[CTR_INSTRET][63:32];
			CSR_MEIE0:         rdata = meie0;
			// Read-only custom registers
			CSR_MEIP0: begin
				decode_match = !wen;
				rdata        = meip0;
			end
			CSR_MLEI: begin
				decode_match = !wen;
				rdata        = {27'd0, mlei};
			end
			default: decode_match = 1'b0;
		endcase
	end

	assign illegal = (wen || ren) && !decode_match;

endmodule

`default_nettype wire

//--- source/csr_top.sv
// Machine-mode CSR block
`default_nettype none

module csr_top (
	input  wire                     clk,
	input  wire                     rst_n,
	input  wire csr_pkg::csr_addr_t  addr,
	input  wire csr_pkg::xlen_t      wdata,
	input  wire                     wen,
	input  wire csr_pkg::csr_wtype_e wtype,
	input  wire                     ren,
	output csr_pkg::xlen_t          rdata,
	output logic                    illegal,
	output csr_pkg::xlen_t          trap_addr,
	output logic                    trap_is_irq,
	output logic                    trap_enter_vld,
	input  wire                     trap_enter_rdy,
	input  wire csr_pkg::xlen_t      mepc_in,
	input  wire csr_pkg::except_e    except,
	input  wire                     delay_irq_entry,
	input  wire csr_pkg::irq_vec_t   irq,
	input  wire                     irq_software,
	input  wire                     irq_timer,
	input  wire                     instr_ret
);
	import csr_pkg::*;

	logic [N_COUNTERS-1:0] ctr_inc, ctr_wen_lo, ctr_wen_hi;
	logic                  inhibit_cy, inhibit_ir;
	count_t                counts [N_COUNTERS];
	logic                  trap_take, trap_return, cause_irq;
	cause_code_t           cause_code, mcause_code;
	logic                  mstatus_mie, mstatus_mpie, mcause_irq;
	xlen_t                 mie, meie0, mtvec, mepc, mip, meip0;
	logic [4:0]            mlei;

	csr_counter_access u_ctr_access (
		.clk, .rst_n, .addr, .wdata, .wtype, .wen, .instr_ret,
		.inc(ctr_inc), .wen_lo(ctr_wen_lo), .wen_hi(ctr_wen_hi), .inhibit_cy, .inhibit_ir
	);

	// mcycle and minstret slices
	for (genvar g = 0; g < N_COUNTERS; g++) begin : g_ctr
		csr_counter_slice u_slice (
			.clk, .rst_n, .inc(ctr_inc[g]), .wen_lo(ctr_wen_lo[g]), .wen_hi(ctr_wen_hi[g]),
			.wdata, .wtype, .count(counts[g])
		);
	end

	csr_mtrap_regs u_mtrap_regs (
		.clk, .rst_n, .addr, .wdata, .wtype, .wen, .trap_take, .trap_return, .cause_irq,
		.cause_code, .mepc_in, .mstatus_mie, .mstatus_mpie, .mie, .meie0, .mtvec, .mepc,
		.mcause_irq, .mcause_code
	);

	csr_trap_ctrl u_trap_ctrl (
		.clk, .rst_n, .irq, .irq_software, .irq_timer, .delay_irq_entry, .except,
		.trap_enter_rdy, .mstatus_mie, .mie, .meie0, .mtvec, .mepc, .mip, .meip0, .mlei,
		.trap_enter_vld, .trap_is_irq, .trap_addr, .trap_take, .trap_return, .cause_irq,
		.cause_code
	);

	csr_read_mux u_read_mux (
		.addr, .wen, .ren, .mstatus_mie, .mstatus_mpie, .mie, .meie0, .mtvec, .mepc,
		.mcause_irq, .mcause_code, .mip, .meip0, .mlei, .inhibit_cy, .inhibit_ir, .counts,
		.rdata, .illegal
	);

endmodule

`default_nettype wire

//--- verification/csr_tb.sv
// CSR block testbench
`default_nettype none

module csr_tb;
	import csr_pkg::*;

	logic       clk;
	logic       rst_n;
	csr_addr_t  addr;
	xlen_t      wdata;
	logic       wen;
	csr_wtype_e wtype;
	logic       ren;
	xlen_t      rdata;
	logic       illegal;
	xlen_t      trap_addr;
	logic       trap_is_irq;
	logic       trap_enter_vld;
	logic       trap_enter_rdy;
	xlen_t      mepc_in;
	except_e    except;
	logic       delay_irq_entry;
	irq_vec_t   irq;
	logic       irq_software;
	logic       irq_timer;
	logic       instr_ret;

	int          err_cnt;
	int          test_cnt;
	int          fail_cnt;
	int          test_err_base; // err_cnt when the running test started
	logic [31:0] rng;           // xorshift state
	xlen_t       mepc_model;    // Expected mepc
	xlen_t       mie_model;     // Expected mie

	csr_top uut (
		.clk, .rst_n, .addr, .wdata, .wen, .wtype, .ren, .rdata, .illegal, .trap_addr,
		.trap_is_irq, .trap_enter_vld, .trap_enter_rdy, .mepc_in, .except, .delay_irq_entry,
		.irq, .irq_software, .irq_timer, .instr_ret
	);

	initial clk = 1'b0;
	always #50 clk = ~clk; // Period 100

	// ------------------------------
	// Helpers
	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic csr_wtype_e pick_wtype(input logic [1:0] sel);
		csr_wtype_e t;
		if (sel == 2'd0)
			t = wtype_write;
		else if (sel == 2'd1)
			t = wtype_set;
		else
			t = wtype_clear; // Two codes map here
		return t;
	endfunction

	// Expected register after an access, bits outside mask never move
	function automatic xlen_t merge_model(input xlen_t old, input xlen_t data,
		input csr_wtype_e t, input xlen_t mask);
		xlen_t d;
		xlen_t res;
		d = data & mask;
		case (t)
			wtype_set:   res = old | d;
			wtype_clear: res = old & ~d;
			default:     res = (old & ~mask) | d;
		endcase
		return res;
	endfunction

	task automatic check_val(input string name, input xlen_t got, input xlen_t exp);
		assert (got === exp) else begin
			$display("Fail %s got %h expected %h", name, got, exp);
			err_cnt++;
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		assert (got === exp) else begin
			$display("Fail %s got %h expected %h", name, got, exp);
			err_cnt++;
		end
	endtask

	task automatic check_cond(input logic ok, input string what);
		assert (ok) else begin
			$display("Error: %s", what);
			err_cnt++;
		end
	endtask

	task automatic end_test(input string name);
		test_cnt++;
		if (err_cnt == test_err_base) begin
			$display("Test %s passed", name);
		end else begin
			fail_cnt++;
			$display("Test %s failed with %0d errors", name, err_cnt - test_err_base);
		end
		test_err_base = err_cnt;
	endtask

	// ------------------------------
	// Bus access, one cycle each, sampled at the falling edge
	task automatic csr_access(input csr_addr_t a, input xlen_t d, input csr_wtype_e t,
		input logic w, input logic r, output xlen_t rd, output logic ill);
		@(posedge clk);
		addr  <= a;
		wdata <= d;
		wtype <= t;
		wen   <= w;
		ren   <= r;
		@(negedge clk);
		rd  = rdata; // Combinational read port
		ill = illegal;
	endtask

	task automatic csr_write(input csr_addr_t a, input xlen_t d, input csr_wtype_e t);
		xlen_t rd;
		logic  ill;
		csr_access(a, d, t, 1'b1, 1'b0, rd, ill);
	endtask

	task automatic csr_read(input csr_addr_t a, output xlen_t d);
		logic ill;
		csr_access(a, '0, wtype_write, 1'b0, 1'b1, d, ill);
	endtask

	task automatic idle_cycle();
		@(posedge clk);
		wen <= 1'b0;
		ren <= 1'b0;
	endtask

	task automatic wait_vld(input int max_cycles, output logic seen);
		seen = 1'b0;
		for (int i = 0; i < max_cycles && !seen; i++) begin
			@(negedge clk);
			seen = trap_enter_vld;
		end
	endtask

	// ------------------------------
	// Tests
	task automatic test_reset();
		@(negedge clk);
		check_bit("trap_enter_vld", trap_enter_vld, 1'b0);
		check_bit("illegal", illegal, 1'b0);
		end_test("reset");
	endtask

	task automatic test_reg_writes();
		xlen_t      rd;
		csr_wtype_e t;
		for (int i = 0; i < 16; i++) begin
			rng = xorshift32(rng);
			t   = pick_wtype(rng[1:0]);
			if (rng[2]) begin
				rng = xorshift32(rng);
				csr_write(CSR_MEPC, rng, t);
				mepc_model = merge_model(mepc_model, rng, t, MEPC_MASK);
				csr_read(CSR_MEPC, rd);
				check_val("mepc", rd, mepc_model);
			end else begin
				rng = xorshift32(rng);
				csr_write(CSR_MIE, rng, t);
				mie_model = merge_model(mie_model, rng, t, MIE_WMASK);
				csr_read(CSR_MIE, rd);
				check_val("mie", rd, mie_model);
			end
		end
		end_test("register writes");
	endtask

	task automatic test_counters();
		xlen_t v0;
		xlen_t v1;
		xlen_t hi;
		int    gap;
		int    n_ret;
		rng = xorshift32(rng);
		gap = int'(rng[2:0]) + 2;
		csr_read(CSR_MCYCLE, v0);
		for (int i = 1; i < gap; i++)
			idle_cycle();
		csr_read(CSR_MCYCLE, v1); // gap edges after the first read
		check_val("mcycle delta", v1 - v0, gap);
		// Stopped counter
		csr_write(CSR_MCOUNTINHIBIT, 32'h1, wtype_write);
		csr_read(CSR_MCYCLE, v0);
		repeat (3) idle_cycle();
		csr_read(CSR_MCYCLE, v1);
		check_val("mcycle inhibited", v1, v0);
		csr_write(CSR_MCOUNTINHIBIT, 32'h1, wtype_clear);
		rng = xorshift32(rng);
		hi  = rng;
		csr_write(CSR_MCYCLEH, hi, wtype_write);
		csr_read(CSR_MCYCLEH, v1);
		check_val("mcycleh", v1, hi);
		// Random retire pattern
		n_ret = 0;
		csr_read(CSR_MINSTRET, v0);
		for (int i = 0; i < 20; i++) begin
			rng = xorshift32(rng);
			@(posedge clk);
			instr_ret <= rng[0];
			if (rng[0])
				n_ret++;
		end
		@(posedge clk);
		instr_ret <= 1'b0;
		csr_read(CSR_MINSTRET, v1);
		check_val("minstret delta", v1 - v0, n_ret);
		end_test("counters");
	endtask

	task automatic test_illegal();
		xlen_t rd;
		logic  ill;
		csr_access(12'h7c0, '0, wtype_write, 1'b0, 1'b1, rd, ill); // Unmapped
		check_bit("illegal unmapped", ill, 1'b1);
		csr_access(CSR_MEIP0, 32'hffff_ffff, wtype_write, 1'b1, 1'b0, rd, ill);
		check_bit("illegal meip0 write", ill, 1'b1);
		csr_access(CSR_MSTATUS, '0, wtype_write, 1'b0, 1'b1, rd, ill);
		check_bit("illegal mstatus read", ill, 1'b0);
		end_test("illegal access");
	endtask

	task automatic test_exception();
		xlen_t rd;
		xlen_t base;
		xlen_t pc;
		rng  = xorshift32(rng);
		base = rng & 32'hffff_fffc; // Direct mode
		csr_write(CSR_MTVEC, base, wtype_write);
		csr_write(CSR_MSTATUS, 32'h8, wtype_set);
		rng = xorshift32(rng);
		pc  = rng | 32'h1; // Odd so bit 0 clearing shows
		idle_cycle();
		except  <= except_ecall;
		mepc_in <= pc;
		@(negedge clk);
		check_bit("trap_enter_vld", trap_enter_vld, 1'b1);
		check_val("trap_addr", trap_addr, base);
		check_bit("trap_is_irq", trap_is_irq, 1'b0);
		// Held off, rdy low
		csr_read(CSR_MEPC, rd);
		check_val("mepc stalled", rd, mepc_model);
		csr_read(CSR_MCAUSE, rd);
		check_val("mcause stalled", rd, 32'h0);
		csr_read(CSR_MSTATUS, rd);
		check_val("mstatus stalled", rd, 32'h0000_1808); // MPP 3, mie
		idle_cycle();
		trap_enter_rdy <= 1'b1;
		idle_cycle();
		trap_enter_rdy <= 1'b0;
		except         <= except_none;
		mepc_model = pc & 32'hffff_fffe;
		csr_read(CSR_MEPC, rd);
		check_val("mepc", rd, mepc_model);
		csr_read(CSR_MCAUSE, rd);
		check_val("mcause", rd, 32'd11);
		csr_read(CSR_MSTATUS, rd);
		check_val("mstatus after trap", rd, 32'h0000_1880); // mpie only
		// ------------------------------
		// Return
		idle_cycle();
		except <= except_mret;
		@(negedge clk);
		check_bit("trap_enter_vld mret", trap_enter_vld, 1'b1);
		check_val("trap_addr mret", trap_addr, mepc_model);
		csr_read(CSR_MSTATUS, rd);
		check_val("mstatus mret stalled", rd, 32'h0000_1880);
		idle_cycle();
		trap_enter_rdy <= 1'b1;
		idle_cycle();
		trap_enter_rdy <= 1'b0;
		except         <= except_none;
		csr_read(CSR_MSTATUS, rd);
		check_val("mstatus after mret", rd, 32'h0000_1888);
		end_test("exception and return");
	endtask

	task automatic test_interrupt();
		xlen_t      rd;
		xlen_t      base;
		logic [3:0] k;
		irq_vec_t   k_mask;
		logic       seen;
		rng    = xorshift32(rng);
		k      = rng[3:0];
		k_mask = irq_vec_t'(1) << k;
		base   = {rng[31:8], 8'h00}; // Vector table base
		csr_write(CSR_MTVEC, base | 32'h1, wtype_write);
		csr_write(CSR_MIE, 32'h800, wtype_write); // meie only
		csr_write(CSR_MEIE0, {16'd0, k_mask}, wtype_set);
		csr_write(CSR_MSTATUS, 32'h8, wtype_set);
		idle_cycle();
		delay_irq_entry <= 1'b1;
		irq             <= k_mask;
		for (int i = 0; i < 4; i++) begin
			@(negedge clk);
			check_bit("trap_enter_vld delayed", trap_enter_vld, 1'b0);
		end
		@(posedge clk);
		delay_irq_entry <= 1'b0;
		wait_vld(8, seen);
		check_cond(seen, "trap_enter_vld did not rise for the external interrupt");
		check_val("trap_addr irq", trap_addr, base + 32'd44); // Vector 11
		check_bit("trap_is_irq", trap_is_irq, 1'b1);
		csr_read(CSR_MLEI, rd);
		check_val("mlei", rd, {28'd0, k});
		idle_cycle();
		trap_enter_rdy <= 1'b1;
		idle_cycle();
		trap_enter_rdy <= 1'b0;
		irq            <= '0;
		csr_read(CSR_MCAUSE, rd);
		check_val("mcause irq", rd, 32'h8000_000b);
		end_test("external interrupts");
	endtask

	// ------------------------------
	// Main sequence
	initial begin
		rst_n           <= 1'b0;
		addr            <= '0;
		wdata           <= '0;
		wen             <= 1'b0;
		wtype           <= wtype_write;
		ren             <= 1'b0;
		trap_enter_rdy  <= 1'b0;
		mepc_in         <= '0;
		except          <= except_none;
		delay_irq_entry <= 1'b0;
		irq             <= '0;
		irq_software    <= 1'b0;
		irq_timer       <= 1'b0;
		instr_ret       <= 1'b0;
		err_cnt       = 0;
		test_cnt      = 0;
		fail_cnt      = 0;
		test_err_base = 0;
		rng           = 32'h06a9_c102;
		mepc_model    = '0;
		mie_model     = '0;
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
		test_reset();
		test_reg_writes();
		test_counters();
		test_illegal();
		test_exception();
		test_interrupt();
		$display("Tests run %0d, failed %0d, check errors %0d", test_cnt, fail_cnt, err_cnt);
		if (err_cnt == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- all.f
source/csr_pkg.sv
source/csr_counter_access.sv
source/csr_counter_slice.sv
source/csr_mtrap_regs.sv
source/csr_trap_ctrl.sv
source/csr_read_mux.sv
source/csr_top.sv
verification/csr_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module csr_tb -Mdir obj_dir -f all.f \
	&& ./obj_dir/Vcsr_tb | tee sim.log \
	|| { echo "Build or run error"; exit 1; }
grep -q "Simulation failed" sim.log && { echo "FAILED"; exit 1; }
grep -q "Simulation completed successfully" sim.log || { echo "No result line"; exit 1; }
echo "PASSED"
exit 0
